/* logic/vdec_pkg.sv */
package vdec_pkg;

  localparam int instr_w = 32;

  typedef logic [4:0] reg_idx_t;
  typedef logic [2:0] vsew_t;
  typedef logic [2:0] vlmul_t;

  typedef enum logic [6:0] {
    LOAD_FP   = 7'b0000111,
    STORE_FP  = 7'b0100111,
    VECTOR_OP = 7'b1010111
  } opcode_e;

  typedef enum logic [2:0] {
    OPIVV = 3'b000,
    OPFVV = 3'b001,
    OPMVV = 3'b010,
    OPIVI = 3'b011,
    OPIVX = 3'b100,
    OPFVF = 3'b101,
    OPMVX = 3'b110,
    OPCFG = 3'b111
  } vfunct3_e;

  // arithmetic layout
  typedef struct packed {
    logic [5:0] funct6;
    logic       vm;
    reg_idx_t   vs2;
    reg_idx_t   vs1;
    vfunct3_e   funct3;
    reg_idx_t   vd;
    opcode_e    opcode;
  } arith_fmt_t;

  // configuration layout, bit 30 doubles as zimm[10] and as second select bit
  typedef struct packed {
    logic        sel_hi;
    logic [10:0] zimm;
    reg_idx_t    rs1;
    vfunct3_e    funct3;
    reg_idx_t    rd;
    opcode_e     opcode;
  } cfg_fmt_t;

  typedef union packed {
    arith_fmt_t arith;
    cfg_fmt_t   cfg;
  } vinstr_u;

  typedef enum logic [5:0] {
    OP_VADD, OP_VSUB, OP_VRSUB, OP_VMINU, OP_VMIN, OP_VMAXU, OP_VMAX,
    OP_VAND, OP_VOR, OP_VXOR, OP_VMSEQ, OP_VMSNE, OP_VMSLTU, OP_VMSLT,
    OP_VSLL, OP_VSRL, OP_VSRA,
    OP_VREDSUM, OP_VREDAND, OP_VREDOR, OP_VREDXOR,
    OP_VMUL, OP_VMULH, OP_VMULHU, OP_VDIVU, OP_VDIV, OP_VREMU, OP_VREM,
    OP_VWADDU, OP_VWADD, OP_VWSUBU, OP_VWSUB,
    OP_CFG, OP_BAD
  } vop_e;

  typedef enum logic [2:0] {FU_ARITH, FU_RED, FU_MUL, FU_DIV, FU_CFG} fu_e;

  typedef enum logic [3:0] {
    ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, COMP, MM, NONE
  } valu_e;

  typedef enum logic [1:0] {SRC_V, SRC_X, SRC_I} src_e;

  typedef enum logic [1:0] {NOT_CFG, VSETVLI, VSETIVLI, VSETVL} cfg_sel_e;

  // OPI space funct6
  localparam logic [5:0] F6_VADD   = 6'b000000;
  localparam logic [5:0] F6_VSUB   = 6'b000010;
  localparam logic [5:0] F6_VRSUB  = 6'b000011;
  localparam logic [5:0] F6_VMINU  = 6'b000100;
  localparam logic [5:0] F6_VMIN   = 6'b000101;
  localparam logic [5:0] F6_VMAXU  = 6'b000110;
  localparam logic [5:0] F6_VMAX   = 6'b000111;
  localparam logic [5:0] F6_VAND   = 6'b001001;
  localparam logic [5:0] F6_VOR    = 6'b001010;
  localparam logic [5:0] F6_VXOR   = 6'b001011;
  localparam logic [5:0] F6_VMSEQ  = 6'b011000;
  localparam logic [5:0] F6_VMSNE  = 6'b011001;
  localparam logic [5:0] F6_VMSLTU = 6'b011010;
  localparam logic [5:0] F6_VMSLT  = 6'b011011;
  localparam logic [5:0] F6_VSLL   = 6'b100101;
  localparam logic [5:0] F6_VSRL   = 6'b101000;
  localparam logic [5:0] F6_VSRA   = 6'b101001;

  // OPM space funct6
  localparam logic [5:0] F6_VREDSUM = 6'b000000;
  localparam logic [5:0] F6_VREDAND = 6'b000001;
  localparam logic [5:0] F6_VREDOR  = 6'b000010;
  localparam logic [5:0] F6_VREDXOR = 6'b000011;
  localparam logic [5:0] F6_VDIVU   = 6'b100000;
  localparam logic [5:0] F6_VDIV    = 6'b100001;
  localparam logic [5:0] F6_VREMU   = 6'b100010;
  localparam logic [5:0] F6_VREM    = 6'b100011;
  localparam logic [5:0] F6_VMULHU  = 6'b100100;
  localparam logic [5:0] F6_VMUL    = 6'b100101;
  localparam logic [5:0] F6_VMULH   = 6'b100111;
  localparam logic [5:0] F6_VWADDU  = 6'b110000;
  localparam logic [5:0] F6_VWADD   = 6'b110001;
  localparam logic [5:0] F6_VWSUBU  = 6'b110010;
  localparam logic [5:0] F6_VWSUB   = 6'b110011;

endpackage

/* logic/vdec_class.sv */
`timescale 1ns/1ps

module vdec_class (
  input  vdec_pkg::vinstr_u  instr,
  output logic               is_opi,
  output logic               is_opm,
  output vdec_pkg::cfg_sel_e cfg_sel,
  output vdec_pkg::src_e     rs1_src,
  output vdec_pkg::reg_idx_t vd,
  output vdec_pkg::reg_idx_t vs1,
  output vdec_pkg::reg_idx_t vs2,
  output logic               vm,
  output logic [10:0]        zimm
);
  import vdec_pkg::*;

  logic     is_vec;
  logic     is_cfg;
  vfunct3_e f3;

  assign is_vec = (instr.arith.opcode == VECTOR_OP);
  assign f3     = instr.arith.funct3;
  assign is_opi = is_vec && (f3 inside {OPIVV, OPIVX, OPIVI});
  assign is_opm = is_vec && (f3 inside {OPMVV, OPMVX});
  assign is_cfg = (instr.cfg.opcode == VECTOR_OP) && (instr.cfg.funct3 == OPCFG);

  // form select on bits 31:30
  always_comb begin
    cfg_sel = NOT_CFG;
    if (is_cfg) begin
      case ({instr.cfg.sel_hi, instr.cfg.zimm[10]})
        2'b11:   cfg_sel = VSETIVLI;
        2'b10:   cfg_sel = VSETVL;
        default: cfg_sel = VSETVLI;
      endcase
    end
  end

  always_comb begin
    rs1_src = SRC_V;
    if (is_vec) begin
      case (f3)
        OPIVX, OPMVX: rs1_src = SRC_X;
        OPIVI:        rs1_src = SRC_I;
        // vsetivli carries uimm, the other two read x[rs1]
        OPCFG:        rs1_src = (cfg_sel == VSETIVLI) ? SRC_I : SRC_X;
        default:      rs1_src = SRC_V;
      endcase
    end
  end

  assign vd   = instr.arith.vd;
  assign vs1  = instr.arith.vs1;
  assign vs2  = instr.arith.vs2;
  assign vm   = instr.arith.vm;
  assign zimm = instr.cfg.zimm;

endmodule

/* logic/vdec_op_lookup.sv */
`timescale 1ns/1ps

module vdec_op_lookup (
  input  logic               is_opi,
  input  logic               is_opm,
  input  vdec_pkg::vfunct3_e funct3,
  input  logic [5:0]         funct6,
  output vdec_pkg::vop_e     op
);
  import vdec_pkg::*;

  logic no_imm;
  logic no_vec;
  logic mvv;

  // narrower form sets within a category
  assign no_imm = (funct3 != OPIVI);
  assign no_vec = (funct3 != OPIVV);
  assign mvv    = (funct3 == OPMVV);

  always_comb begin
    op = OP_BAD;
    if (is_opi) begin
      case (funct6)
        F6_VADD:   op = OP_VADD;
        F6_VSUB:   op = no_imm ? OP_VSUB : OP_BAD;
        F6_VRSUB:  op = no_vec ? OP_VRSUB : OP_BAD;
        F6_VMINU:  op = no_imm ? OP_VMINU : OP_BAD;
        F6_VMIN:   op = no_imm ? OP_VMIN : OP_BAD;
        F6_VMAXU:  op = no_imm ? OP_VMAXU : OP_BAD;
        F6_VMAX:   op = no_imm ? OP_VMAX : OP_BAD;
        F6_VAND:   op = OP_VAND;
        F6_VOR:    op = OP_VOR;
        F6_VXOR:   op = OP_VXOR;
        F6_VMSEQ:  op = OP_VMSEQ;
        F6_VMSNE:  op = OP_VMSNE;
        F6_VMSLTU: op = no_imm ? OP_VMSLTU : OP_BAD;
        F6_VMSLT:  op = no_imm ? OP_VMSLT : OP_BAD;
        F6_VSLL:   op = OP_VSLL;
        F6_VSRL:   op = OP_VSRL;
        F6_VSRA:   op = OP_VSRA;
        default:   op = OP_BAD;
      endcase
    end else if (is_opm) begin
      case (funct6)
        // reductions only exist as .vs
        F6_VREDSUM: op = mvv ? OP_VREDSUM : OP_BAD;
        F6_VREDAND: op = mvv ? OP_VREDAND : OP_BAD;
        F6_VREDOR:  op = mvv ? OP_VREDOR : OP_BAD;
        F6_VREDXOR: op = mvv ? OP_VREDXOR : OP_BAD;
        F6_VDIVU:   op = OP_VDIVU;
        F6_VDIV:    op = OP_VDIV;
        F6_VREMU:   op = OP_VREMU;
        F6_VREM:    op = OP_VREM;
        F6_VMULHU:  op = OP_VMULHU;
        F6_VMUL:    op = OP_VMUL;
        F6_VMULH:   op = OP_VMULH;
        F6_VWADDU:  op = OP_VWADDU;
        F6_VWADD:   op = OP_VWADD;
        F6_VWSUBU:  op = OP_VWSUBU;
        F6_VWSUB:   op = OP_VWSUB;
        default:    op = OP_BAD;
      endcase
    end
  end

endmodule

/* logic/vdec_ctrl_gen.sv */
`timescale 1ns/1ps

module vdec_ctrl_gen (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               in_valid,
  input  vdec_pkg::vop_e     op,
  input  vdec_pkg::cfg_sel_e cfg_sel,
  input  vdec_pkg::src_e     rs1_src,
  input  vdec_pkg::reg_idx_t vd,
  input  vdec_pkg::reg_idx_t vs1,
  input  vdec_pkg::reg_idx_t vs2,
  input  logic               vm,
  input  logic               wide_ok,
  input  logic               vec_ok,
  output logic               out_valid,
  output vdec_pkg::vop_e     out_op,
  output logic               out_illegal,
  output vdec_pkg::fu_e      out_fu,
  output vdec_pkg::valu_e    out_aluop,
  output logic               out_signed,
  output logic               out_vd_widen,
  output logic               out_mask_result,
  output vdec_pkg::src_e     out_rs1_src,
  output vdec_pkg::reg_idx_t out_vd,
  output vdec_pkg::reg_idx_t out_vs1,
  output vdec_pkg::reg_idx_t out_vs2,
  output logic               out_vm
);
  import vdec_pkg::*;

  vop_e  dec_op;
  fu_e   fu;
  valu_e aluop;
  logic  is_signed;
  logic  widen;
  logic  mask_res;
  logic  illegal;

  assign dec_op = (cfg_sel != NOT_CFG) ? OP_CFG : op;

  always_comb begin
    case (dec_op)
      OP_VREDSUM, OP_VREDAND, OP_VREDOR, OP_VREDXOR:   fu = FU_RED;
      OP_VMUL, OP_VMULH, OP_VMULHU:                    fu = FU_MUL;
      OP_VDIVU, OP_VDIV, OP_VREMU, OP_VREM:            fu = FU_DIV;
      OP_CFG:                                          fu = FU_CFG;
      default:                                         fu = FU_ARITH;
    endcase
  end

  always_comb begin
    case (dec_op)
      OP_VADD, OP_VREDSUM, OP_VWADDU, OP_VWADD:        aluop = ADD;
      OP_VSUB, OP_VRSUB, OP_VWSUBU, OP_VWSUB:          aluop = SUB;
      OP_VAND, OP_VREDAND:                             aluop = AND;
      OP_VOR, OP_VREDOR:                               aluop = OR;
      OP_VXOR, OP_VREDXOR:                             aluop = XOR;
      OP_VSLL:                                         aluop = SLL;
      OP_VSRL:                                         aluop = SRL;
      OP_VSRA:                                         aluop = SRA;
      OP_VMSEQ, OP_VMSNE, OP_VMSLTU, OP_VMSLT:         aluop = COMP;
      OP_VMINU, OP_VMIN, OP_VMAXU, OP_VMAX:            aluop = MM;
      default:                                         aluop = NONE;
    endcase
  end

  // signed half of each signed/unsigned pair
  assign is_signed = dec_op inside {OP_VMIN, OP_VMAX, OP_VMSLT, OP_VSRA, OP_VWADD,
                                    OP_VWSUB, OP_VMULH, OP_VDIV, OP_VREM};
  assign widen     = dec_op inside {OP_VWADDU, OP_VWADD, OP_VWSUBU, OP_VWSUB};
  assign mask_res  = dec_op inside {OP_VMSEQ, OP_VMSNE, OP_VMSLTU, OP_VMSLT};

  // vtype checks use the state left by the previous config instruction
  assign illegal = (dec_op == OP_BAD) || ((dec_op != OP_CFG) && !vec_ok) ||
                   (widen && !wide_ok);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      out_op          <= dec_op;
      out_illegal     <= illegal;
      out_fu          <= fu;
      out_aluop       <= aluop;
      out_signed      <= is_signed;
      out_vd_widen    <= widen;
      out_mask_result <= mask_res;
      out_rs1_src     <= rs1_src;
      out_vd          <= vd;
      out_vs1         <= vs1;
      out_vs2         <= vs2;
      out_vm          <= vm;
    end
  end

endmodule

/* logic/vtype_cfg_reg.sv */
`timescale 1ns/1ps

module vtype_cfg_reg #(
  parameter int elen = 32
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               in_valid,
  input  vdec_pkg::cfg_sel_e cfg_sel,
  input  logic [10:0]        zimm,
  output vdec_pkg::vsew_t    vsew,
  output vdec_pkg::vlmul_t   vlmul,
  output logic               vill,
  output logic               wide_ok,
  output logic               vec_ok
);
  import vdec_pkg::*;

  // vsew code whose element width equals elen
  localparam vsew_t elen_sew = vsew_t'($clog2(elen / 8));

  logic   load;
  logic   rsvd_bits;
  logic   bad_cfg;
  vsew_t  new_sew;
  vlmul_t new_lmul;

  assign load     = in_valid && ((cfg_sel == VSETVLI) || (cfg_sel == VSETIVLI));
  assign new_lmul = zimm[2:0];
  assign new_sew  = zimm[5:3];

  // vsetivli only has ten zimm bits
  assign rsvd_bits = (cfg_sel == VSETIVLI) ? |zimm[9:8] : |zimm[10:8];
  assign bad_cfg   = rsvd_bits || (new_sew > elen_sew) || (new_lmul == 3'b100);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vsew  <= '0;
      vlmul <= '0;
      vill  <= 1'b1;
    end else if (load) begin
      vsew  <= new_sew;
      vlmul <= new_lmul;
      vill  <= bad_cfg;
    end
  end

  assign wide_ok = (vsew < elen_sew) && !vill;
  assign vec_ok  = !vill;

endmodule

/* logic/vdec_top.sv */
`timescale 1ns/1ps

module vdec_top #(
  parameter int elen = 32
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          in_valid,
  input  logic [vdec_pkg::instr_w-1:0]  instr,
  output logic                          out_valid,
  output vdec_pkg::vop_e                out_op,
  output logic                          out_illegal,
  output vdec_pkg::fu_e                 out_fu,
  output vdec_pkg::valu_e               out_aluop,
  output logic                          out_signed,
  output logic                          out_vd_widen,
  output logic                          out_mask_result,
  output vdec_pkg::src_e                out_rs1_src,
  output vdec_pkg::reg_idx_t            out_vd,
  output vdec_pkg::reg_idx_t            out_vs1,
  output vdec_pkg::reg_idx_t            out_vs2,
  output logic                          out_vm,
  output vdec_pkg::vsew_t               vsew,
  output vdec_pkg::vlmul_t              vlmul,
  output logic                          vill
);
  import vdec_pkg::*;

  vinstr_u     instr_u;
  logic        is_opi;
  logic        is_opm;
  cfg_sel_e    cfg_sel;
  src_e        rs1_src;
  reg_idx_t    vd;
  reg_idx_t    vs1;
  reg_idx_t    vs2;
  logic        vm;
  logic [10:0] zimm;
  vop_e        op;
  logic        wide_ok;
  logic        vec_ok;

  assign instr_u = instr;

  vdec_class i_vdec_class (
    .instr   (instr_u),
    .is_opi  (is_opi),
    .is_opm  (is_opm),
    .cfg_sel (cfg_sel),
    .rs1_src (rs1_src),
    .vd      (vd),
    .vs1     (vs1),
    .vs2     (vs2),
    .vm      (vm),
    .zimm    (zimm)
  );

  vdec_op_lookup i_vdec_op_lookup (
    .is_opi (is_opi),
    .is_opm (is_opm),
    .funct3 (instr_u.arith.funct3),
    .funct6 (instr_u.arith.funct6),
    .op     (op)
  );

  vtype_cfg_reg #(
    .elen (elen)
  ) i_vtype_cfg_reg (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .cfg_sel  (cfg_sel),
    .zimm     (zimm),
    .vsew     (vsew),
    .vlmul    (vlmul),
    .vill     (vill),
    .wide_ok  (wide_ok),
    .vec_ok   (vec_ok)
  );

  vdec_ctrl_gen i_vdec_ctrl_gen (
    .clk             (clk),
    .rst_n           (rst_n),
    .in_valid        (in_valid),
    .op              (op),
    .cfg_sel         (cfg_sel),
    .rs1_src         (rs1_src),
    .vd              (vd),
    .vs1             (vs1),
    .vs2             (vs2),
    .vm              (vm),
    .wide_ok         (wide_ok),
    .vec_ok          (vec_ok),
    .out_valid       (out_valid),
    .out_op          (out_op),
    .out_illegal     (out_illegal),
    .out_fu          (out_fu),
    .out_aluop       (out_aluop),
    .out_signed      (out_signed),
    .out_vd_widen    (out_vd_widen),
    .out_mask_result (out_mask_result),
    .out_rs1_src     (out_rs1_src),
    .out_vd          (out_vd),
    .out_vs1         (out_vs1),
    .out_vs2         (out_vs2),
    .out_vm          (out_vm)
  );

endmodule

/* test/vdec_model.svh */
`ifndef VDEC_MODEL_SVH
`define VDEC_MODEL_SVH

// expected decoder response for one strobed word
typedef struct packed {
  vop_e        op;
  logic        illegal;
  fu_e         fu;
  valu_e       aluop;
  logic        sgn;
  logic        widen;
  logic        mask;
  src_e        rs1_src;
  reg_idx_t    vd;
  reg_idx_t    vs1;
  reg_idx_t    vs2;
  logic        vm;
  vsew_t       sew;
  vlmul_t      lmul;
  logic        vill;
  logic [31:0] due;
} dec_exp_t;

// reference copy of vtype
vsew_t  ref_sew;
vlmul_t ref_lmul;
logic   ref_vill;

function automatic logic [5:0] f6_of(vop_e op);
  case (op)
    OP_VADD:    return F6_VADD;
    OP_VSUB:    return F6_VSUB;
    OP_VRSUB:   return F6_VRSUB;
    OP_VMINU:   return F6_VMINU;
    OP_VMIN:    return F6_VMIN;
    OP_VMAXU:   return F6_VMAXU;
    OP_VMAX:    return F6_VMAX;
    OP_VAND:    return F6_VAND;
    OP_VOR:     return F6_VOR;
    OP_VXOR:    return F6_VXOR;
    OP_VMSEQ:   return F6_VMSEQ;
    OP_VMSNE:   return F6_VMSNE;
    OP_VMSLTU:  return F6_VMSLTU;
    OP_VMSLT:   return F6_VMSLT;
    OP_VSLL:    return F6_VSLL;
    OP_VSRL:    return F6_VSRL;
    OP_VSRA:    return F6_VSRA;
    OP_VREDSUM: return F6_VREDSUM;
    OP_VREDAND: return F6_VREDAND;
    OP_VREDOR:  return F6_VREDOR;
    OP_VREDXOR: return F6_VREDXOR;
    OP_VMUL:    return F6_VMUL;
    OP_VMULH:   return F6_VMULH;
    OP_VMULHU:  return F6_VMULHU;
    OP_VDIVU:   return F6_VDIVU;
    OP_VDIV:    return F6_VDIV;
    OP_VREMU:   return F6_VREMU;
    OP_VREM:    return F6_VREM;
    OP_VWADDU:  return F6_VWADDU;
    OP_VWADD:   return F6_VWADD;
    OP_VWSUBU:  return F6_VWSUBU;
    default:    return F6_VWSUB;
  endcase
endfunction

// which funct3 forms exist for each kept op
function automatic logic form_ok(vop_e op, vfunct3_e f3);
  if (op inside {OP_VSUB, OP_VMINU, OP_VMIN, OP_VMAXU, OP_VMAX, OP_VMSLTU, OP_VMSLT})
    return f3 inside {OPIVV, OPIVX};
  if (op == OP_VRSUB)
    return f3 inside {OPIVX, OPIVI};
  if (op inside {OP_VREDSUM, OP_VREDAND, OP_VREDOR, OP_VREDXOR})
    return f3 == OPMVV;
  if (op >= OP_VMUL && op <= OP_VWSUB)
    return f3 inside {OPMVV, OPMVX};
  return f3 inside {OPIVV, OPIVX, OPIVI};
endfunction

// search every kept op for a matching funct6 and form
function automatic vop_e lookup_op(vfunct3_e f3, logic [5:0] f6);
  vop_e cand;
  vop_e found;
  found = OP_BAD;
  for (int i = 0; i <= int'(OP_VWSUB); i++) begin
    cand = vop_e'(i);
    if (f6_of(cand) == f6 && form_ok(cand, f3)) found = cand;
  end
  return found;
endfunction

function automatic fu_e fu_of(vop_e op);
  if (op inside {OP_VREDSUM, OP_VREDAND, OP_VREDOR, OP_VREDXOR}) return FU_RED;
  if (op inside {OP_VMUL, OP_VMULH, OP_VMULHU}) return FU_MUL;
  if (op inside {OP_VDIVU, OP_VDIV, OP_VREMU, OP_VREM}) return FU_DIV;
  if (op == OP_CFG) return FU_CFG;
  return FU_ARITH;
endfunction

function automatic valu_e aluop_of(vop_e op);
  case (op)
    OP_VADD, OP_VREDSUM, OP_VWADDU, OP_VWADD: return ADD;
    OP_VSUB, OP_VRSUB, OP_VWSUBU, OP_VWSUB:   return SUB;
    OP_VAND, OP_VREDAND:                      return AND;
    OP_VOR, OP_VREDOR:                        return OR;
    OP_VXOR, OP_VREDXOR:                      return XOR;
    OP_VSLL:                                  return SLL;
    OP_VSRL:                                  return SRL;
    OP_VSRA:                                  return SRA;
    OP_VMSEQ, OP_VMSNE, OP_VMSLTU, OP_VMSLT:  return COMP;
    OP_VMINU, OP_VMIN, OP_VMAXU, OP_VMAX:     return MM;
    default:                                  return NONE;
  endcase
endfunction

function automatic logic [31:0] encode_arith(vop_e op, vfunct3_e f3, logic vm,
                                             reg_idx_t vd, reg_idx_t vs1, reg_idx_t vs2);
  return {f6_of(op), vm, vs2, vs1, f3, vd, VECTOR_OP};
endfunction

function automatic logic [31:0] encode_vsetvli(logic [10:0] zimm, reg_idx_t rd, reg_idx_t rs1);
  return {1'b0, zimm, rs1, OPCFG, rd, VECTOR_OP};
endfunction

function automatic logic [31:0] encode_vsetivli(logic [9:0] zimm, reg_idx_t rd,
                                                logic [4:0] uimm);
  return {2'b11, zimm, uimm, OPCFG, rd, VECTOR_OP};
endfunction

function automatic logic [31:0] encode_vsetvl(reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
  return {7'b1000000, rs2, rs1, OPCFG, rd, VECTOR_OP};
endfunction

// predicts all outputs and advances the reference vtype
function automatic dec_exp_t predict(logic [31:0] w);
  dec_exp_t e;
  logic     is_vec;
  vfunct3_e f3;
  cfg_sel_e form;
  logic     rsvd;
  logic     wide_ok;
  is_vec = (w[6:0] == VECTOR_OP);
  f3     = vfunct3_e'(w[14:12]);
  form   = NOT_CFG;
  if (is_vec && f3 == OPCFG) begin
    if (!w[31]) form = VSETVLI;
    else if (w[30]) form = VSETIVLI;
    else form = VSETVL;
  end
  if (form != NOT_CFG) e.op = OP_CFG;
  else if (is_vec) e.op = lookup_op(f3, w[31:26]);
  else e.op = OP_BAD;
  e.fu    = fu_of(e.op);
  e.aluop = aluop_of(e.op);
  e.sgn   = e.op inside {OP_VMIN, OP_VMAX, OP_VMSLT, OP_VSRA, OP_VWADD, OP_VWSUB,
                         OP_VMULH, OP_VDIV, OP_VREM};
  e.widen = e.op inside {OP_VWADDU, OP_VWADD, OP_VWSUBU, OP_VWSUB};
  e.mask  = e.op inside {OP_VMSEQ, OP_VMSNE, OP_VMSLTU, OP_VMSLT};
  if (!is_vec) e.rs1_src = SRC_V;
  else if (f3 inside {OPIVX, OPMVX}) e.rs1_src = SRC_X;
  else if (f3 == OPIVI) e.rs1_src = SRC_I;
  else if (f3 == OPCFG) e.rs1_src = (form == VSETIVLI) ? SRC_I : SRC_X;
  else e.rs1_src = SRC_V;
  // legality sees the vtype from before this word
  wide_ok   = ((8 << ref_sew) < elen) && !ref_vill;
  e.illegal = (e.op == OP_BAD) || (e.op != OP_CFG && ref_vill) || (e.widen && !wide_ok);
  e.vd  = w[11:7];
  e.vs1 = w[19:15];
  e.vs2 = w[24:20];
  e.vm  = w[25];
  if (form == VSETVLI || form == VSETIVLI) begin
    rsvd     = (form == VSETIVLI) ? |w[29:28] : |w[30:28];
    ref_sew  = w[25:23];
    ref_lmul = w[22:20];
    ref_vill = rsvd || ((8 << w[25:23]) > elen) || (w[22:20] == 3'b100);
  end
  e.sew  = ref_sew;
  e.lmul = ref_lmul;
  e.vill = ref_vill;
  e.due  = '0;
  return e;
endfunction

`endif

/* test/vdec_tb.sv */
`timescale 1ns/1ps

module vdec_tb;
  import vdec_pkg::*;

  localparam int elen = 32;

  logic               clk = 1'b0;
  logic               rst_n;
  logic               in_valid;
  logic [instr_w-1:0] instr;
  logic               out_valid;
  vop_e               out_op;
  logic               out_illegal;
  fu_e                out_fu;
  valu_e              out_aluop;
  logic               out_signed;
  logic               out_vd_widen;
  logic               out_mask_result;
  src_e               out_rs1_src;
  reg_idx_t           out_vd;
  reg_idx_t           out_vs1;
  reg_idx_t           out_vs2;
  logic               out_vm;
  vsew_t              vsew;
  vlmul_t             vlmul;
  logic               vill;

  int          errors = 0;
  int          checks = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  logic        timed_out = 1'b0;
  logic [31:0] neg_cnt = '0;

  `include "vdec_model.svh"

  dec_exp_t pending[$];

  vdec_top #(
    .elen (elen)
  ) i_vdec_top (
    .clk             (clk),
    .rst_n           (rst_n),
    .in_valid        (in_valid),
    .instr           (instr),
    .out_valid       (out_valid),
    .out_op          (out_op),
    .out_illegal     (out_illegal),
    .out_fu          (out_fu),
    .out_aluop       (out_aluop),
    .out_signed      (out_signed),
    .out_vd_widen    (out_vd_widen),
    .out_mask_result (out_mask_result),
    .out_rs1_src     (out_rs1_src),
    .out_vd          (out_vd),
    .out_vs1         (out_vs1),
    .out_vs2         (out_vs2),
    .out_vm          (out_vm),
    .vsew            (vsew),
    .vlmul           (vlmul),
    .vill            (vill)
  );

  always #2 clk = ~clk;

  task automatic compare_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // outputs are settled by the falling edge
  always @(negedge clk) begin : output_checker
    dec_exp_t e;
    neg_cnt = neg_cnt + 1;
    if (out_valid === 1'b1) begin
      if (pending.size() == 0) begin
        errors++;
        $display("out_valid was high with no instruction pending");
      end else begin
        e = pending.pop_front();
        compare_val("latency", neg_cnt, e.due);
        compare_val("out_op", out_op, e.op);
        compare_val("out_illegal", out_illegal, e.illegal);
        compare_val("out_fu", out_fu, e.fu);
        compare_val("out_aluop", out_aluop, e.aluop);
        compare_val("out_signed", out_signed, e.sgn);
        compare_val("out_vd_widen", out_vd_widen, e.widen);
        compare_val("out_mask_result", out_mask_result, e.mask);
        compare_val("out_rs1_src", out_rs1_src, e.rs1_src);
        compare_val("out_vd", out_vd, e.vd);
        compare_val("out_vs1", out_vs1, e.vs1);
        compare_val("out_vs2", out_vs2, e.vs2);
        compare_val("out_vm", out_vm, e.vm);
        compare_val("vsew", vsew, e.sew);
        compare_val("vlmul", vlmul, e.lmul);
        compare_val("vill", vill, e.vill);
      end
    end
  end

  // strobe sampled at the next edge, visible at the second falling edge from now
  task automatic issue(input logic [31:0] w);
    dec_exp_t e;
    e = predict(w);
    @(posedge clk);
    e.due = neg_cnt + 2;
    pending.push_back(e);
    in_valid <= 1'b1;
    instr    <= w;
  endtask

  task automatic wait_drain;
    int cycles;
    cycles = 0;
    while (pending.size() != 0 && cycles < 10) begin
      @(posedge clk);
      cycles++;
    end
    if (pending.size() != 0) begin
      $display("timeout: %0d results never arrived on out_valid", pending.size());
      timed_out = 1'b1;
    end
  endtask

  task automatic end_burst;
    @(posedge clk);
    in_valid <= 1'b0;
    wait_drain();
  endtask

  function automatic vfunct3_e pick_form(vop_e op);
    vfunct3_e cand[$];
    int       idx;
    for (int i = 0; i < 8; i++) begin
      if (form_ok(op, vfunct3_e'(i))) cand.push_back(vfunct3_e'(i));
    end
    idx = int'($urandom_range(cand.size() - 1, 0));
    return cand[idx];
  endfunction

  function automatic vlmul_t random_lmul();
    vlmul_t l;
    l = vlmul_t'($urandom);
    // skip the reserved code
    if (l == 3'b100) l = 3'b000;
    return l;
  endfunction

  task automatic issue_op(input vop_e op, input vfunct3_e f3);
    issue(encode_arith(op, f3, 1'($urandom), reg_idx_t'($urandom), reg_idx_t'($urandom),
                       reg_idx_t'($urandom)));
  endtask

  task automatic set_vtype(input vsew_t sew, input vlmul_t lmul);
    issue(encode_vsetvli({3'b000, 2'($urandom), sew, lmul}, reg_idx_t'($urandom),
                         reg_idx_t'($urandom)));
  endtask

  task automatic reset_state;
    @(negedge clk);
    compare_val("out_valid", out_valid, 1'b0);
    compare_val("vsew", vsew, 3'd0);
    compare_val("vlmul", vlmul, 3'd0);
    compare_val("vill", vill, 1'b1);
    issue_op(OP_VADD, OPIVV);
    end_burst();
  endtask

  task automatic config_vtype;
    for (int s = 0; s < 3; s++) begin
      set_vtype(vsew_t'(s), random_lmul());
    end
    // SEW 64 is wider than elen
    issue(encode_vsetivli({4'b0000, 3'd3, 3'd0}, reg_idx_t'($urandom), 5'($urandom)));
    end_burst();
  endtask

  task automatic random_legal_ops;
    vop_e op;
    repeat (8) begin
      set_vtype(vsew_t'($urandom_range(2, 0)), random_lmul());
      repeat (25) begin
        op = vop_e'($urandom_range(int'(OP_VWSUB), 0));
        issue_op(op, pick_form(op));
      end
    end
    end_burst();
  endtask

  task automatic widening_legality;
    vsew_t sews[$];
    sews = '{3'd0, 3'd2};
    foreach (sews[k]) begin
      set_vtype(sews[k], 3'd0);
      for (int i = int'(OP_VWADDU); i <= int'(OP_VWSUB); i++) begin
        issue_op(vop_e'(i), OPMVV);
        issue_op(vop_e'(i), OPMVX);
      end
    end
    end_burst();
  endtask

  task automatic bad_encodings;
    logic [31:0] w;
    set_vtype(3'd1, 3'd0);
    repeat (60) issue($urandom);
    repeat (30) begin
      w = {6'($urandom), 1'($urandom), 10'($urandom),
           3'($urandom_range(6, 0)), 5'($urandom), VECTOR_OP};
      issue(w);
    end
    // kept funct6 in a form that does not exist
    issue_op(OP_VSUB, OPIVI);
    issue_op(OP_VRSUB, OPIVV);
    issue_op(OP_VMIN, OPIVI);
    issue_op(OP_VMSLT, OPIVI);
    issue_op(OP_VREDSUM, OPMVX);
    issue_op(OP_VADD, OPFVV);
    repeat (30) begin
      w = $urandom;
      if (w[6:0] == VECTOR_OP) w[0] = ~w[0];
      issue(w);
    end
    end_burst();
  endtask

  task automatic vsetvl_keeps_vtype;
    set_vtype(3'd1, 3'd1);
    repeat (10) begin
      issue(encode_vsetvl(reg_idx_t'($urandom), reg_idx_t'($urandom), reg_idx_t'($urandom)));
      issue_op(OP_VADD, OPIVX);
    end
    end_burst();
  endtask

  task automatic report_test(input int num, input string name, input int err_start);
    tests_run++;
    if (errors == err_start && !timed_out) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: fail, %0d errors", num, name, errors - err_start);
    end
  endtask

  initial begin
    int err_start;
    rst_n    = 1'b0;
    in_valid = 1'b0;
    instr    = '0;
    ref_sew  = '0;
    ref_lmul = '0;
    ref_vill = 1'b1;
    void'($urandom(32'hb61a_24aa));
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    err_start = errors;
    reset_state();
    report_test(1, "reset state", err_start);
    if (!timed_out) begin
      err_start = errors;
      config_vtype();
      report_test(2, "vtype configuration", err_start);
    end
    if (!timed_out) begin
      err_start = errors;
      random_legal_ops();
      report_test(3, "random legal ops", err_start);
    end
    if (!timed_out) begin
      err_start = errors;
      widening_legality();
      report_test(4, "widening legality", err_start);
    end
    if (!timed_out) begin
      err_start = errors;
      bad_encodings();
      report_test(5, "bad encodings", err_start);
    end
    if (!timed_out) begin
      err_start = errors;
      vsetvl_keeps_vtype();
      report_test(6, "vsetvl keeps vtype", err_start);
    end

    if (timed_out) $display("run stopped early after a timeout");
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0 && tests_failed == 0 && !timed_out) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+test
logic/vdec_pkg.sv
logic/vdec_class.sv
logic/vdec_op_lookup.sv
logic/vdec_ctrl_gen.sv
logic/vtype_cfg_reg.sv
logic/vdec_top.sv
test/vdec_tb.sv

/* Bender.yml */
package:
  name: vdec

sources:
  - logic/vdec_pkg.sv
  - logic/vdec_class.sv
  - logic/vdec_op_lookup.sv
  - logic/vdec_ctrl_gen.sv
  - logic/vtype_cfg_reg.sv
  - logic/vdec_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/vdec_tb.sv
